// ==== source/huff_pkg.sv ====
// Fixed Deflate Huffman tables only; lengths and distances above 64 are not encoded
package huff_pkg;

  // Input and code word widths
  localparam int LIT_DAT_WD  = 8;
  localparam int LEN_DAT_WD  = 7;
  localparam int DIS_DAT_WD  = 7;
  localparam int LIT_CODE_WD = 9;
  localparam int LEN_CODE_WD = 10;
  localparam int DIS_CODE_WD = 9;
  localparam int CODE_WD_WD  = 4;

  localparam int LEN_HUFF_WD = 7;
  localparam int LEN_EXT_WD  = LEN_CODE_WD - LEN_HUFF_WD;
  localparam int DIS_HUFF_WD = 5;
  localparam int DIS_EXT_WD  = DIS_CODE_WD - DIS_HUFF_WD;

  typedef logic [LIT_DAT_WD-1:0]  lit_dat_t;
  typedef logic [LEN_DAT_WD-1:0]  len_dat_t;
  typedef logic [DIS_DAT_WD-1:0]  dis_dat_t;
  typedef logic [LIT_CODE_WD-1:0] lit_code_t;
  typedef logic [LEN_CODE_WD-1:0] len_code_t;
  typedef logic [DIS_CODE_WD-1:0] dis_code_t;
  typedef logic [CODE_WD_WD-1:0]  code_wd_t;

  //--------------------------------------------------------------------------
  // Literal codes are 8 bit up to LIT_SPLIT and 9 bit above
  localparam lit_dat_t  LIT_SPLIT = 8'd143;
  localparam lit_code_t LIT_BASE8 = 9'd48;
  localparam lit_code_t LIT_BASE9 = 9'd400;

  //--------------------------------------------------------------------------
  // Length ranges
  localparam len_dat_t LEN_LIM0   = 7'd10;
  localparam len_dat_t LEN_LIM1   = 7'd18;
  localparam len_dat_t LEN_LIM2   = 7'd34;
  localparam len_dat_t LEN_MAX    = 7'd64;
  localparam len_dat_t LEN_START0 = 7'd3;
  localparam len_dat_t LEN_START1 = 7'd11;
  localparam len_dat_t LEN_START2 = 7'd19;
  localparam len_dat_t LEN_START3 = 7'd35;
  localparam logic [LEN_HUFF_WD-1:0] LEN_BASE0 = 7'd1;
  localparam logic [LEN_HUFF_WD-1:0] LEN_BASE1 = 7'd9;
  localparam logic [LEN_HUFF_WD-1:0] LEN_BASE2 = 7'd13;
  localparam logic [LEN_HUFF_WD-1:0] LEN_BASE3 = 7'd17;

  //--------------------------------------------------------------------------
  // Distance ranges
  localparam dis_dat_t DIS_LIM0   = 7'd4;
  localparam dis_dat_t DIS_LIM1   = 7'd8;
  localparam dis_dat_t DIS_LIM2   = 7'd16;
  localparam dis_dat_t DIS_LIM3   = 7'd32;
  localparam dis_dat_t DIS_MAX    = 7'd64;
  localparam dis_dat_t DIS_START0 = 7'd1;
  localparam dis_dat_t DIS_START1 = 7'd5;
  localparam dis_dat_t DIS_START2 = 7'd9;
  localparam dis_dat_t DIS_START3 = 7'd17;
  localparam dis_dat_t DIS_START4 = 7'd33;
  localparam logic [DIS_HUFF_WD-1:0] DIS_BASE0 = 5'd0;
  localparam logic [DIS_HUFF_WD-1:0] DIS_BASE1 = 5'd4;
  localparam logic [DIS_HUFF_WD-1:0] DIS_BASE2 = 5'd6;
  localparam logic [DIS_HUFF_WD-1:0] DIS_BASE3 = 5'd8;
  localparam logic [DIS_HUFF_WD-1:0] DIS_BASE4 = 5'd10;

endpackage

// ==== source/huff_code_if.sv ====
// Carries the combinational code/width pairs; no valid, the register stage samples them
`timescale 1ns/1ps

interface huff_code_if import huff_pkg::*; ();

  lit_code_t lit_code;
  code_wd_t  lit_wd;
  len_code_t len_code;
  code_wd_t  len_wd;
  dis_code_t dis_code;
  code_wd_t  dis_wd;

  // One source modport per encoder
  modport lit_src (
    output lit_code,
    output lit_wd
  );

  modport len_src (
    output len_code,
    output len_wd
  );

  modport dis_src (
    output dis_code,
    output dis_wd
  );

  modport sink (
    input lit_code,
    input lit_wd,
    input len_code,
    input len_wd,
    input dis_code,
    input dis_wd
  );

endinterface

// ==== source/huff_lit_enc.sv ====
// Combinational fixed literal code, right aligned; every byte value is legal
`timescale 1ns/1ps

module huff_lit_enc import huff_pkg::*; (
  input lit_dat_t      lit_dat_i,
  huff_code_if.lit_src code
);

  logic      short_code;
  lit_code_t lit_off;

  //--------------------------------------------------------------------------
  // Range select
  assign short_code = (lit_dat_i <= LIT_SPLIT);

  // Offset into the 9 bit range starts at LIT_SPLIT + 1
  assign lit_off = lit_code_t'(lit_dat_i - LIT_SPLIT - 8'd1);

  //--------------------------------------------------------------------------
  // Code and width
  always_comb begin
    if (short_code) begin
      code.lit_code = LIT_BASE8 + lit_code_t'(lit_dat_i);
      code.lit_wd   = code_wd_t'(LIT_CODE_WD - 1);
    end else begin
      code.lit_code = LIT_BASE9 + lit_off;
      code.lit_wd   = code_wd_t'(LIT_CODE_WD);
    end
  end

endmodule

// ==== source/huff_len_enc.sv ====
// Combinational fixed length code for 3 to 64; other lengths give code 0 with range width
`timescale 1ns/1ps

module huff_len_enc import huff_pkg::*; (
  input len_dat_t      len_dat_i,
  huff_code_if.len_src code
);

  logic [$clog2(LEN_EXT_WD+1)-1:0] ext_wd;
  len_dat_t                        start;
  logic [LEN_HUFF_WD-1:0]          base;
  len_dat_t                        off;
  logic [LEN_HUFF_WD-1:0]          huff;
  logic [LEN_EXT_WD-1:0]           ext_raw;
  logic [LEN_EXT_WD-1:0]           ext_flip;
  logic [LEN_EXT_WD-1:0]           ext_rev;
  logic                            in_range;

  //--------------------------------------------------------------------------
  // Range decode
  always_comb begin
    if (len_dat_i <= LEN_LIM0) begin
      ext_wd = 2'd0;
      start  = LEN_START0;
      base   = LEN_BASE0;
    end else if (len_dat_i <= LEN_LIM1) begin
      ext_wd = 2'd1;
      start  = LEN_START1;
      base   = LEN_BASE1;
    end else if (len_dat_i <= LEN_LIM2) begin
      ext_wd = 2'd2;
      start  = LEN_START2;
      base   = LEN_BASE2;
    end else begin
      ext_wd = 2'd3;
      start  = LEN_START3;
      base   = LEN_BASE3;
    end
  end

  //--------------------------------------------------------------------------
  // Offset splits into symbol step and extra bits
  assign off      = len_dat_i - start;
  assign huff     = base + LEN_HUFF_WD'(off >> ext_wd);
  assign ext_raw  = off[LEN_EXT_WD-1:0] & ~({LEN_EXT_WD{1'b1}} << ext_wd);

  // Extra bits go out LSB first, so reverse them over their own width
  assign ext_flip = {<<{ext_raw}};
  assign ext_rev  = ext_flip >> (LEN_EXT_WD - ext_wd);

  assign in_range = (len_dat_i >= LEN_START0) && (len_dat_i <= LEN_MAX);

  //--------------------------------------------------------------------------
  // Right aligned code word
  assign code.len_code = in_range ?
                         ((LEN_CODE_WD'(huff) << ext_wd) | LEN_CODE_WD'(ext_rev)) :
                         '0;
  assign code.len_wd   = code_wd_t'(LEN_HUFF_WD) + code_wd_t'(ext_wd);

endmodule

// ==== source/huff_dis_enc.sv ====
// Combinational fixed distance code for 1 to 64; other distances give code 0 with range width
`timescale 1ns/1ps

module huff_dis_enc import huff_pkg::*; (
  input dis_dat_t      dis_dat_i,
  huff_code_if.dis_src code
);

  logic [$clog2(DIS_EXT_WD+1)-1:0] ext_wd;
  dis_dat_t                        start;
  logic [DIS_HUFF_WD-1:0]          base;
  dis_dat_t                        off;
  logic [DIS_HUFF_WD-1:0]          huff;
  logic [DIS_EXT_WD-1:0]           ext_raw;
  logic [DIS_EXT_WD-1:0]           ext_flip;
  logic [DIS_EXT_WD-1:0]           ext_rev;
  logic                            in_range;

  //--------------------------------------------------------------------------
  // Decode of the five distance ranges
  always_comb begin
    if (dis_dat_i <= DIS_LIM0) begin
      ext_wd = 3'd0;
      start  = DIS_START0;
      base   = DIS_BASE0;
    end else if (dis_dat_i <= DIS_LIM1) begin
      ext_wd = 3'd1;
      start  = DIS_START1;
      base   = DIS_BASE1;
    end else if (dis_dat_i <= DIS_LIM2) begin
      ext_wd = 3'd2;
      start  = DIS_START2;
      base   = DIS_BASE2;
    end else if (dis_dat_i <= DIS_LIM3) begin
      ext_wd = 3'd3;
      start  = DIS_START3;
      base   = DIS_BASE3;
    end else begin
      ext_wd = 3'd4;
      start  = DIS_START4;
      base   = DIS_BASE4;
    end
  end

  //--------------------------------------------------------------------------
  // Symbol step is one per 2^ext_wd distances
  assign off      = dis_dat_i - start;
  assign huff     = base + DIS_HUFF_WD'(off >> ext_wd);
  assign ext_raw  = off[DIS_EXT_WD-1:0] & ~({DIS_EXT_WD{1'b1}} << ext_wd);

  // Reverse across the full field, then drop the unused low bits
  assign ext_flip = {<<{ext_raw}};
  assign ext_rev  = ext_flip >> (DIS_EXT_WD - ext_wd);

  assign in_range = (dis_dat_i >= DIS_START0) && (dis_dat_i <= DIS_MAX);

  assign code.dis_code = in_range ?
                         ((DIS_CODE_WD'(huff) << ext_wd) | DIS_CODE_WD'(ext_rev)) :
                         '0;
  assign code.dis_wd   = code_wd_t'(DIS_HUFF_WD) + code_wd_t'(ext_wd);

endmodule

// ==== source/huff_code_reg.sv ====
// One cycle output stage; fields load only when val_i is high and hold otherwise
`timescale 1ns/1ps

module huff_code_reg import huff_pkg::*; (
  input  logic             clk,
  input  logic             rst_i,
  input  logic             val_i,
  huff_code_if.sink        code,
  output logic             val_o,
  output lit_code_t        lit_code_o,
  output code_wd_t         lit_code_wd_o,
  output len_code_t        len_code_o,
  output code_wd_t         len_code_wd_o,
  output dis_code_t        dis_code_o,
  output code_wd_t         dis_code_wd_o
);

  //--------------------------------------------------------------------------
  // Strobe follows val_i every cycle
  always_ff @(posedge clk) begin
    if (rst_i) begin
      val_o <= 1'b0;
    end else begin
      val_o <= val_i;
    end
  end

  //--------------------------------------------------------------------------
  // Code and width capture
  always_ff @(posedge clk) begin
    if (rst_i) begin
      lit_code_o    <= '0;
      lit_code_wd_o <= '0;
      len_code_o    <= '0;
      len_code_wd_o <= '0;
      dis_code_o    <= '0;
      dis_code_wd_o <= '0;
    end else if (val_i) begin
      lit_code_o    <= code.lit_code;
      lit_code_wd_o <= code.lit_wd;
      len_code_o    <= code.len_code;
      len_code_wd_o <= code.len_wd;
      dis_code_o    <= code.dis_code;
      dis_code_wd_o <= code.dis_wd;
    end
  end

endmodule

// ==== source/huffman_fixed_core.sv ====
// Fixed Huffman encoder for literal, length and distance; 1 cycle latency, no back-pressure
`timescale 1ns/1ps

module huffman_fixed_core import huff_pkg::*; (
  input  logic      clk,
  input  logic      rst_i,
  input  logic      val_i,
  input  lit_dat_t  lit_dat_i,
  input  len_dat_t  len_dat_i,
  input  dis_dat_t  dis_dat_i,
  output logic      val_o,
  output lit_code_t lit_code_o,
  output code_wd_t  lit_code_wd_o,
  output len_code_t len_code_o,
  output code_wd_t  len_code_wd_o,
  output dis_code_t dis_code_o,
  output code_wd_t  dis_code_wd_o
);

  // Encoder results before the output register
  huff_code_if code_if ();

  //--------------------------------------------------------------------------
  // Combinational encoders
  huff_lit_enc huff_lit_enc_inst (
    .lit_dat_i (lit_dat_i),
    .code      (code_if.lit_src)
  );

  huff_len_enc huff_len_enc_inst (
    .len_dat_i (len_dat_i),
    .code      (code_if.len_src)
  );

  huff_dis_enc huff_dis_enc_inst (
    .dis_dat_i (dis_dat_i),
    .code      (code_if.dis_src)
  );

  //--------------------------------------------------------------------------
  // Output stage
  huff_code_reg huff_code_reg_inst (
    .clk           (clk),
    .rst_i         (rst_i),
    .val_i         (val_i),
    .code          (code_if.sink),
    .val_o         (val_o),
    .lit_code_o    (lit_code_o),
    .lit_code_wd_o (lit_code_wd_o),
    .len_code_o    (len_code_o),
    .len_code_wd_o (len_code_wd_o),
    .dis_code_o    (dis_code_o),
    .dis_code_wd_o (dis_code_wd_o)
  );

endmodule

// ==== verification/huffman_fixed_core_chk.sv ====
// Bound into huffman_fixed_core; assumes reset is applied at the first clock edge
`timescale 1ns/1ps

module huffman_fixed_core_chk import huff_pkg::*; (
  input logic      clk,
  input logic      rst_i,
  input logic      val_i,
  input logic      val_o,
  input lit_code_t lit_code_o,
  input code_wd_t  lit_code_wd_o,
  input len_code_t len_code_o,
  input code_wd_t  len_code_wd_o,
  input dis_code_t dis_code_o,
  input code_wd_t  dis_code_wd_o
);

  // Number of assertion failures so far
  int fail_count = 0;

  // ------------------------------------------------------------------------
  // Strobe is val_i one cycle late
  val_delay_a : assert property (@(posedge clk) !rst_i |=> (val_o == $past(val_i)))
    else begin
      $error("val_o does not follow val_i by one cycle");
      fail_count++;
    end

  // Literal codes are 8 or 9 bits
  lit_width_a : assert property (@(posedge clk) val_o |-> (lit_code_wd_o inside {4'd8, 4'd9}))
    else begin
      $error("literal code width out of range while val_o is high");
      fail_count++;
    end

  // ------------------------------------------------------------------------
  // Everything clear after a reset cycle
  reset_clear_a : assert property (@(posedge clk) rst_i |=>
      (val_o == 1'b0 && lit_code_o == '0 && lit_code_wd_o == '0 &&
       len_code_o == '0 && len_code_wd_o == '0 &&
       dis_code_o == '0 && dis_code_wd_o == '0))
    else begin
      $error("outputs not cleared in the cycle after reset");
      fail_count++;
    end

endmodule

// ==== verification/huffman_fixed_core_tb.sv ====
// Self-checking testbench; expects exactly one cycle from val_i to val_o and no back-pressure
`timescale 1ns/1ps

module huffman_fixed_core_tb import huff_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam int NUM_RAND   = 200;

  typedef struct {
    string name;
    bit    val;
    int    lit;
    int    len;
    int    dis;
    int    lit_code;
    int    lit_wd;
    int    len_code;
    int    len_wd;
    int    dis_code;
    int    dis_wd;
  } vec_t;

  logic      clk;
  logic      rst_i;
  logic      val_i;
  lit_dat_t  lit_dat_i;
  len_dat_t  len_dat_i;
  dis_dat_t  dis_dat_i;
  logic      val_o;
  lit_code_t lit_code_o;
  code_wd_t  lit_code_wd_o;
  len_code_t len_code_o;
  code_wd_t  len_code_wd_o;
  dis_code_t dis_code_o;
  code_wd_t  dis_code_wd_o;

  vec_t        vec_q[$];
  vec_t        exp_q[$];
  vec_t        hold;
  logic [31:0] seed;
  int          err_count;
  int          check_count;
  bit          table_ready;

  huffman_fixed_core huffman_fixed_core_inst (
    .clk           (clk),
    .rst_i         (rst_i),
    .val_i         (val_i),
    .lit_dat_i     (lit_dat_i),
    .len_dat_i     (len_dat_i),
    .dis_dat_i     (dis_dat_i),
    .val_o         (val_o),
    .lit_code_o    (lit_code_o),
    .lit_code_wd_o (lit_code_wd_o),
    .len_code_o    (len_code_o),
    .len_code_wd_o (len_code_wd_o),
    .dis_code_o    (dis_code_o),
    .dis_code_wd_o (dis_code_wd_o)
  );

  bind huffman_fixed_core huffman_fixed_core_chk huffman_fixed_core_chk_inst (
    .clk           (clk),
    .rst_i         (rst_i),
    .val_i         (val_i),
    .val_o         (val_o),
    .lit_code_o    (lit_code_o),
    .lit_code_wd_o (lit_code_wd_o),
    .len_code_o    (len_code_o),
    .len_code_wd_o (len_code_wd_o),
    .dis_code_o    (dis_code_o),
    .dis_code_wd_o (dis_code_wd_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Reference model straight from the fixed code rules
  function automatic int rev_bits(input int v, input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      r = (r << 1) | ((v >> i) & 1);
    end
    return r;
  endfunction

  function automatic vec_t ref_model(input string name, input int lit, input int len,
                                     input int dis);
    vec_t v;
    // Range starts and base codes, indexed by the extra bit count
    int   len_start[4] = '{3, 11, 19, 35};
    int   len_base[4]  = '{1, 9, 13, 17};
    int   dis_start[5] = '{1, 5, 9, 17, 33};
    int   dis_base[5]  = '{0, 4, 6, 8, 10};
    int   ext;
    int   off;
    v.name = name;
    v.val  = 1'b1;
    v.lit  = lit;
    v.len  = len;
    v.dis  = dis;
    v.lit_code = (lit <= 143) ? 48 + lit : 400 + lit - 144;
    v.lit_wd   = (lit <= 143) ? 8 : 9;
    ext      = (len <= 10) ? 0 : (len <= 18) ? 1 : (len <= 34) ? 2 : 3;
    off      = len - len_start[ext];
    v.len_wd = 7 + ext;
    if (len < 3 || len > 64)
      v.len_code = 0;
    else
      v.len_code = ((len_base[ext] + (off >> ext)) << ext) | rev_bits(off % (1 << ext), ext);
    ext      = (dis <= 4) ? 0 : (dis <= 8) ? 1 : (dis <= 16) ? 2 : (dis <= 32) ? 3 : 4;
    off      = dis - dis_start[ext];
    v.dis_wd = 5 + ext;
    if (dis < 1 || dis > 64)
      v.dis_code = 0;
    else
      v.dis_code = ((dis_base[ext] + (off >> ext)) << ext) | rev_bits(off % (1 << ext), ext);
    return v;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // --------------------------------------------------------------------------
  // Checking
  task automatic check_value(input string name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("CHECK FAILED %s %s: expected 0x%0h, actual 0x%0h",
               name, field, expected, actual);
    end
  endtask

  task automatic compare_outputs();
    vec_t e;
    if (exp_q.size() == 0) begin
      err_count++;
      $display("ERROR: no expected item queued for the outputs at %0t", $time);
    end else begin
      e = exp_q.pop_front();
      check_value(e.name, "val_o", e.val, val_o);
      check_value(e.name, "lit_code_o", e.lit_code, lit_code_o);
      check_value(e.name, "lit_code_wd_o", e.lit_wd, lit_code_wd_o);
      check_value(e.name, "len_code_o", e.len_code, len_code_o);
      check_value(e.name, "len_code_wd_o", e.len_wd, len_code_wd_o);
      check_value(e.name, "dis_code_o", e.dis_code, dis_code_o);
      check_value(e.name, "dis_code_wd_o", e.dis_wd, dis_code_wd_o);
    end
  endtask

  // Previous cycle checked, then the next item driven; gaps expect held outputs
  task automatic apply_item(input vec_t v);
    vec_t e;
    @(negedge clk);
    compare_outputs();
    val_i     = v.val;
    lit_dat_i = lit_dat_t'(v.lit);
    len_dat_i = len_dat_t'(v.len);
    dis_dat_i = dis_dat_t'(v.dis);
    if (v.val) begin
      e    = v;
      hold = v;
    end else begin
      e      = hold;
      e.name = v.name;
      e.val  = 1'b0;
    end
    exp_q.push_back(e);
  endtask

  task automatic add_vector(input string name, input bit val, input int lit, input int len,
                            input int dis, input int lit_code, input int lit_wd,
                            input int len_code, input int len_wd, input int dis_code,
                            input int dis_wd);
    vec_t v;
    v = '{name, val, lit, len, dis, lit_code, lit_wd, len_code, len_wd, dis_code, dis_wd};
    vec_q.push_back(v);
  endtask

  // --------------------------------------------------------------------------
  // Boundary and gap vectors
  // Columns are name val lit len dis then the expected code and width of each field
  task automatic load_table();
    add_vector("lo_bounds",   1,   0,  3,  1,  48, 8,   1,  7,   0, 5);
    add_vector("len10_dis4",  1, 143, 10,  4, 191, 8,   8,  7,   3, 5);
    add_vector("len11_dis5",  1, 144, 11,  5, 400, 9,  18,  8,   8, 6);
    add_vector("len18_dis8",  1, 255, 18,  8, 511, 9,  25,  8,  11, 6);
    add_vector("gap0",        0,  17, 40, 40,   0, 0,   0,  0,   0, 0);
    add_vector("len19_dis9",  1,   1, 19,  9,  49, 8,  52,  9,  24, 7);
    add_vector("len20_dis16", 1, 100, 20, 16, 148, 8,  54,  9,  31, 7);
    add_vector("gap1",        0,  33, 50, 50,   0, 0,   0,  0,   0, 0);
    add_vector("gap2",        0, 250,  2,  0,   0, 0,   0,  0,   0, 0);
    add_vector("len34_dis17", 1, 200, 34, 17, 456, 9,  67,  9,  64, 8);
    add_vector("len35_dis32", 1, 150, 35, 32, 406, 9, 136, 10,  79, 8);
    add_vector("len36_dis33", 1,  65, 36, 33, 113, 8, 140, 10, 160, 9);
    add_vector("len64_dis34", 1, 144, 64, 34, 400, 9, 165, 10, 168, 9);
    add_vector("len3_dis64",  1, 143,  3, 64, 191, 8,   1,  7, 191, 9);
    add_vector("oor_zero",    1, 255,  0,  0, 511, 9,   0,  7,   0, 5);
    add_vector("oor_high",    1,   0, 65, 65,  48, 8,   0, 10,   0, 9);
    add_vector("gap3",        0,   5,  5,  5,   0, 0,   0,  0,   0, 0);
  endtask

  initial begin
    vec_t        v;
    logic [31:0] r;
    int          total;
    rst_i       = 1'b1;
    val_i       = 1'b0;
    lit_dat_i   = '0;
    len_dat_i   = '0;
    dis_dat_i   = '0;
    err_count   = 0;
    check_count = 0;
    seed        = 32'hd167_6592;
    load_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    hold  = '{"reset", 1'b0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
    exp_q.push_back(hold);
    foreach (vec_q[i]) begin
      apply_item(vec_q[i]);
    end
    for (int i = 0; i < NUM_RAND; i++) begin
      r = next_rand();
      v = ref_model($sformatf("rand_%0d", i), r[15:8], r[22:16] % 68, r[29:23] % 67);
      v.val = (r[3:0] != 4'd0);
      apply_item(v);
    end
    v = '{"drain", 1'b0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
    apply_item(v);
    @(negedge clk);
    compare_outputs();
    total = err_count + huffman_fixed_core_inst.huffman_fixed_core_chk_inst.fail_count;
    $display("checks %0d, value errors %0d, assertion errors %0d", check_count, err_count,
             huffman_fixed_core_inst.huffman_fixed_core_chk_inst.fail_count);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the table, the random items and some slack
  initial begin
    wait (table_ready);
    #((vec_q.size() + NUM_RAND + 20) * CLK_PERIOD);
    $display("ERROR: watchdog expired before the stimulus completed");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== filelist.f ====
source/huff_pkg.sv
source/huff_code_if.sv
source/huff_lit_enc.sv
source/huff_len_enc.sv
source/huff_dis_enc.sv
source/huff_code_reg.sv
source/huffman_fixed_core.sv
verification/huffman_fixed_core_chk.sv
verification/huffman_fixed_core_tb.sv
